//--- Makefile
TOP       ?= tb_fetch
FLIST     ?= rv_fetch.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/rv_fetch_pkg.sv
package rv_fetch_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int xlen     = 32;  // address and data width
  localparam int exc_size = 16;  // exception vector width

  ////////////////////////////////////////
  // memory map
  ////////////////////////////////////////

  localparam logic [xlen-1:0] pc_init = 32'h8000_0000;  // first fetch after reset

  // 64 words, so pc_init .. pc_init+255 is backed by memory
  localparam int imem_words = 64;

  ////////////////////////////////////////
  // fixed encodings
  ////////////////////////////////////////

  localparam logic [xlen-1:0] instr_nop     = 32'h0000_0013;  // addi x0,x0,0
  localparam logic [xlen-1:0] instr_wfi     = 32'h1050_0073;  // wfi, runs as nop here
  localparam logic [xlen-1:0] instr_illegal = 32'hffff_ffff;  // marks bad encodings

  // major opcodes, instr[6:2]
  typedef enum logic [4:0] {
    opc_load     = 5'b00000,
    opc_misc_mem = 5'b00011,
    opc_op_imm   = 5'b00100,
    opc_auipc    = 5'b00101,
    opc_store    = 5'b01000,
    opc_amo      = 5'b01011,
    opc_op       = 5'b01100,
    opc_lui      = 5'b01101,
    opc_branch   = 5'b11000,
    opc_jalr     = 5'b11001,
    opc_jal      = 5'b11011,
    opc_system   = 5'b11100
  } opcode_e;

  // bit positions in the exception vector, mcause numbering
  typedef enum logic [3:0] {
    cause_misaligned_fetch   = 4'd0,
    cause_fetch_access_fault = 4'd1
  } cause_e;

endpackage

//--- fetch/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage import rv_fetch_pkg::*; (
  input  logic                clk,
  input  logic                rstn,
  input  logic                id_stall,
  input  logic                bu_flush,
  input  logic                st_flush,
  input  logic [xlen-1:0]     bu_nxt_pc,
  input  logic [xlen-1:0]     st_nxt_pc,
  input  logic [xlen-1:0]     parcel,
  input  logic [xlen-1:0]     parcel_pc,
  input  logic                parcel_valid,
  input  logic                parcel_misaligned,
  input  logic                parcel_fault,
  output logic                fe_flush,      // kills reads in the memory
  output logic                redirect,
  output logic [xlen-1:0]     redirect_pc,
  output logic [xlen-1:0]     if_instr,
  output logic [xlen-1:0]     if_pc,
  output logic                if_bubble,
  output logic [exc_size-1:0] if_exception,
  output logic [1:0]          if_bp_predict  // {static taken, 0}
);

  logic                ext_flush;
  logic [xlen-1:0]     flush_pc;
  logic [exc_size-1:0] parcel_exc;

  // pre-decode slot
  logic [xlen-1:0]     pd_raw;
  logic [xlen-1:0]     pd_pc;
  logic                pd_valid;
  logic [exc_size-1:0] pd_exc;

  logic [xlen-1:0]     pd_instr;
  logic                pred_taken;
  logic [xlen-1:0]     pred_pc;

  ////////////////////////////////////////
  // flush and redirect
  ////////////////////////////////////////

  assign ext_flush = st_flush | bu_flush;
  assign flush_pc  = st_flush ? st_nxt_pc : bu_nxt_pc;  // state flush wins

  // a stalled pd slot does not move, so it must not redirect either
  assign redirect    = pred_taken & ~id_stall;
  assign redirect_pc = pred_pc;

  assign fe_flush = ext_flush | redirect;

  // memory flags into cause positions
  always_comb begin
    parcel_exc                           = '0;
    parcel_exc[cause_misaligned_fetch]   = parcel_misaligned;
    parcel_exc[cause_fetch_access_fault] = parcel_fault;
  end

  ////////////////////////////////////////
  // pre-decode slot
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pd_valid <= 1'b0;
      pd_pc    <= pc_init;
      pd_exc   <= '0;
    end else if (ext_flush) begin
      pd_valid <= 1'b0;          // empty, park on the target
      pd_pc    <= flush_pc;
      pd_exc   <= '0;
    end else if (!id_stall) begin
      if (redirect) begin
        pd_valid <= 1'b0;        // drop the parcel on the wrong path
        pd_pc    <= redirect_pc;
        pd_exc   <= '0;
      end else begin
        pd_valid <= parcel_valid;
        if (parcel_valid) begin
          pd_pc  <= parcel_pc;
          pd_exc <= parcel_exc;  // exceptions ride with the word
        end
      end
    end
  end

  // raw word, only meaningful with pd_valid
  always_ff @(posedge clk) begin
    if (!ext_flush && !id_stall && !redirect && parcel_valid) begin
      pd_raw <= parcel;
    end
  end

  predecode u_predecode (
    .pd_instr_raw (pd_raw),
    .pd_pc        (pd_pc),
    .pd_valid     (pd_valid),
    .pd_instr     (pd_instr),
    .pred_taken   (pred_taken),
    .pred_pc      (pred_pc)
  );

  ////////////////////////////////////////
  // output slot towards decode
  ////////////////////////////////////////

  // flush beats stall
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      if_bubble     <= 1'b1;
      if_instr      <= instr_nop;
      if_pc         <= pc_init;
      if_exception  <= '0;
      if_bp_predict <= 2'b00;
    end else if (ext_flush) begin
      if_bubble     <= 1'b1;
      if_instr      <= instr_nop;
      if_pc         <= flush_pc;
      if_exception  <= '0;
      if_bp_predict <= 2'b00;
    end else if (!id_stall) begin
      if_bubble     <= ~pd_valid;
      if_instr      <= pd_valid ? pd_instr : instr_nop;  // bubble carries nop
      if_pc         <= pd_pc;
      if_exception  <= pd_valid ? pd_exc : '0;
      if_bp_predict <= {pred_taken, 1'b0};              // no bpu, static bit only
    end
  end

endmodule

//--- fetch/pc_gen.sv
`timescale 1ns/100ps

module pc_gen import rv_fetch_pkg::*; (
  input  logic            clk,
  input  logic            rstn,
  input  logic            id_stall,     // decode stall, freezes the fetch address
  input  logic            st_flush,
  input  logic [xlen-1:0] st_nxt_pc,
  input  logic            bu_flush,     // branch unit or debug flush
  input  logic [xlen-1:0] bu_nxt_pc,
  input  logic            redirect,     // static prediction from pre-decode
  input  logic [xlen-1:0] redirect_pc,
  output logic [xlen-1:0] fetch_pc      // address handed to the memory
);

  logic [xlen-1:0] seq_pc;

  assign seq_pc = fetch_pc + 32'd4;  // next word

  ////////////////////////////////////////
  // next fetch address
  ////////////////////////////////////////

  // priority: state flush, branch unit flush, predicted redirect, sequential
  // the flushes are not gated by the stall
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      fetch_pc <= pc_init;
    end else if (st_flush) begin
      fetch_pc <= st_nxt_pc;
    end else if (bu_flush) begin
      fetch_pc <= bu_nxt_pc;
    end else if (redirect) begin
      fetch_pc <= redirect_pc;  // redirect already masked by stall upstream
    end else if (!id_stall) begin
      fetch_pc <= seq_pc;
    end
  end

  // three addresses can be outstanding at once
  //   fetch_pc     being read by the memory
  //   parcel       waiting at the fetch stage input
  //   pd slot      being pre-decoded
  // a redirect from the pd slot throws the other two away

endmodule

//--- fetch/predecode.sv
`timescale 1ns/100ps

module predecode import rv_fetch_pkg::*; (
  input  logic [xlen-1:0] pd_instr_raw,  // word held in the pre-decode slot
  input  logic [xlen-1:0] pd_pc,
  input  logic            pd_valid,      // slot holds a real instruction
  output logic [xlen-1:0] pd_instr,      // legalised word
  output logic            pred_taken,
  output logic [xlen-1:0] pred_pc
);

  logic            is_32bit;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;
  opcode_e         opcode;

  ////////////////////////////////////////
  // legalising
  ////////////////////////////////////////

  assign is_32bit = &pd_instr_raw[1:0];  // only 32 bit parcels supported

  always_comb begin
    if (pd_instr_raw == instr_wfi) begin
      pd_instr = instr_nop;          // wfi behaves as nop
    end else if (is_32bit) begin
      pd_instr = pd_instr_raw;
    end else begin
      pd_instr = instr_illegal;      // compressed or longer, not handled
    end
  end

  ////////////////////////////////////////
  // immediates
  ////////////////////////////////////////

  // b-type, 13 bit signed offset
  assign imm_b = {{(xlen-12){pd_instr[31]}}, pd_instr[7], pd_instr[30:25],
                  pd_instr[11:8], 1'b0};

  // j-type, 21 bit signed offset
  assign imm_j = {{(xlen-20){pd_instr[31]}}, pd_instr[19:12], pd_instr[20],
                  pd_instr[30:21], 1'b0};

  assign opcode = opcode_e'(pd_instr[6:2]);

  ////////////////////////////////////////
  // static prediction
  ////////////////////////////////////////

  // jal always taken
  // branch taken only when backwards (sign of offset set)
  always_comb begin
    case (opcode)
      opc_jal: begin
        pred_taken = pd_valid;
        pred_pc    = pd_pc + imm_j;
      end
      opc_branch: begin
        pred_taken = pd_valid & imm_b[xlen-1];  // backward loop
        pred_pc    = pd_pc + imm_b;
      end
      default: begin
        pred_taken = 1'b0;
        pred_pc    = pd_pc + imm_b;  // unused when not taken
      end
    endcase
  end

endmodule

//--- logic/fetch_top.sv
`timescale 1ns/100ps

module fetch_top import rv_fetch_pkg::*; (
  input  logic                clk,
  input  logic                rstn,
  input  logic                id_stall,
  input  logic                bu_flush,      // branch unit, also debug exit
  input  logic [xlen-1:0]     bu_nxt_pc,
  input  logic                st_flush,
  input  logic [xlen-1:0]     st_nxt_pc,
  output logic [xlen-1:0]     if_instr,
  output logic [xlen-1:0]     if_pc,
  output logic                if_bubble,
  output logic [exc_size-1:0] if_exception,
  output logic [1:0]          if_bp_predict
);

  logic [xlen-1:0] fetch_pc;
  logic [xlen-1:0] parcel;
  logic [xlen-1:0] parcel_pc;
  logic            parcel_valid;
  logic            parcel_misaligned;
  logic            parcel_fault;
  logic            fe_flush;
  logic            redirect;
  logic [xlen-1:0] redirect_pc;

  ////////////////////////////////////////
  // address, memory, fetch
  ////////////////////////////////////////

  pc_gen u_pc_gen (
    .clk         (clk),
    .rstn        (rstn),
    .id_stall    (id_stall),
    .st_flush    (st_flush),
    .st_nxt_pc   (st_nxt_pc),
    .bu_flush    (bu_flush),
    .bu_nxt_pc   (bu_nxt_pc),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetch_pc    (fetch_pc)
  );

  imem_biu u_imem_biu (
    .clk               (clk),
    .rstn              (rstn),
    .id_stall          (id_stall),
    .fe_flush          (fe_flush),
    .fetch_pc          (fetch_pc),
    .parcel            (parcel),
    .parcel_pc         (parcel_pc),
    .parcel_valid      (parcel_valid),
    .parcel_misaligned (parcel_misaligned),
    .parcel_fault      (parcel_fault)
  );

  fetch_stage u_fetch_stage (
    .clk               (clk),
    .rstn              (rstn),
    .id_stall          (id_stall),
    .bu_flush          (bu_flush),
    .st_flush          (st_flush),
    .bu_nxt_pc         (bu_nxt_pc),
    .st_nxt_pc         (st_nxt_pc),
    .parcel            (parcel),
    .parcel_pc         (parcel_pc),
    .parcel_valid      (parcel_valid),
    .parcel_misaligned (parcel_misaligned),
    .parcel_fault      (parcel_fault),
    .fe_flush          (fe_flush),
    .redirect          (redirect),
    .redirect_pc       (redirect_pc),
    .if_instr          (if_instr),
    .if_pc             (if_pc),
    .if_bubble         (if_bubble),
    .if_exception      (if_exception),
    .if_bp_predict     (if_bp_predict)
  );

endmodule

//--- logic/imem_biu.sv
`timescale 1ns/100ps

module imem_biu import rv_fetch_pkg::*; (
  input  logic            clk,
  input  logic            rstn,
  input  logic            id_stall,
  input  logic            fe_flush,          // kills the read in progress
  input  logic [xlen-1:0] fetch_pc,
  output logic [xlen-1:0] parcel,
  output logic [xlen-1:0] parcel_pc,
  output logic            parcel_valid,      // one strobe per accepted read
  output logic            parcel_misaligned,
  output logic            parcel_fault
);

  logic [xlen-1:0] mem [imem_words];

  logic [xlen-1:0]                 offset;
  logic [$clog2(imem_words)-1:0]   word_idx;
  logic                            misaligned;
  logic                            in_range;
  logic [xlen-1:0]                 rd_word;

  initial begin
    $readmemh("sim/prog.hex", mem);  // program image, shared with the testbench
  end

  ////////////////////////////////////////
  // address checks
  ////////////////////////////////////////

  // below pc_init wraps to a large offset, so one compare covers both ends
  assign offset     = fetch_pc - pc_init;
  assign in_range   = offset < xlen'(imem_words * 4);
  assign misaligned = |fetch_pc[1:0];
  assign word_idx   = offset[$clog2(imem_words)+1:2];

  // bad address returns a harmless nop
  assign rd_word = (misaligned || !in_range) ? instr_nop : mem[word_idx];

  ////////////////////////////////////////
  // registered read
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      parcel_valid      <= 1'b0;
      parcel_misaligned <= 1'b0;
      parcel_fault      <= 1'b0;
    end else if (fe_flush) begin
      parcel_valid      <= 1'b0;  // address in flight is stale
      parcel_misaligned <= 1'b0;
      parcel_fault      <= 1'b0;
    end else if (!id_stall) begin
      parcel_valid      <= 1'b1;
      parcel_misaligned <= misaligned;
      parcel_fault      <= ~in_range;
    end
  end

  // data and address, qualified by parcel_valid
  always_ff @(posedge clk) begin
    if (!id_stall) begin
      parcel    <= rd_word;
      parcel_pc <= fetch_pc;
    end
  end

endmodule

//--- rv_fetch.f
common/rv_fetch_pkg.sv
fetch/pc_gen.sv
fetch/predecode.sv
fetch/fetch_stage.sv
logic/imem_biu.sv
logic/fetch_top.sv
sim/tb_fetch.sv

//--- sim/prog.hex
// one instruction word per line, line n is fetched from pc_init + 4*n
// words 0..11 and 21..63 are addi x1,x1,n
00008093
00108093
00208093
00308093
00408093
00508093
00608093
00708093
00808093
00908093
00a08093
00b08093
00000463 // beq x0,x0,+8 forward, predicted not taken
10500073 // wfi
12345670 // low bits 00, not a 32 bit encoding
00c0006f // jal x0,+12
01008093 // skipped by the jal
01108093 // skipped by the jal
01208093
01308093
fe209ce3 // bne x1,x2,-8 backward, loops to word 18
01508093
01608093
01708093
01808093
01908093
01a08093
01b08093
01c08093
01d08093
01e08093
01f08093
02008093
02108093
02208093
02308093
02408093
02508093
02608093
02708093
02808093
02908093
02a08093
02b08093
02c08093
02d08093
02e08093
02f08093
03008093
03108093
03208093
03308093
03408093
03508093
03608093
03708093
03808093
03908093
03a08093
03b08093
03c08093
03d08093
03e08093
03f08093

//--- sim/tb_fetch.sv
`timescale 1ns/100ps

module tb_fetch import rv_fetch_pkg::*; ();

  logic                clk;
  logic                rstn;
  logic                id_stall;
  logic                bu_flush;
  logic [xlen-1:0]     bu_nxt_pc;
  logic                st_flush;
  logic [xlen-1:0]     st_nxt_pc;
  logic [xlen-1:0]     if_instr;
  logic [xlen-1:0]     if_pc;
  logic                if_bubble;
  logic [exc_size-1:0] if_exception;
  logic [1:0]          if_bp_predict;

  // expected result for one fetch address
  typedef struct packed {
    logic [xlen-1:0]     instr;
    logic [xlen-1:0]     next_pc;
    logic                taken;
    logic [exc_size-1:0] exc;
  } expect_t;

  localparam logic [exc_size-1:0] exc_mis   = exc_size'(1) << cause_misaligned_fetch;
  localparam logic [exc_size-1:0] exc_fault = exc_size'(1) << cause_fetch_access_fault;

  logic [xlen-1:0]     prog [imem_words];  // own copy of the program image
  logic [xlen-1:0]     hist_pc[$];         // every non-bubble output in order
  logic [xlen-1:0]     hist_instr[$];
  logic [exc_size-1:0] hist_exc[$];
  logic [1:0]          hist_pred[$];
  int                  errors = 0;
  int                  n_checks = 0;
  int                  flush_mark;         // history length at the flush edge

  // word indices from the forward branch on through the jal and three loop passes
  int path_idx [13] = '{12, 13, 14, 15, 18, 19, 20, 18, 19, 20, 18, 19, 20};

  fetch_top DUT (
    .clk           (clk),
    .rstn          (rstn),
    .id_stall      (id_stall),
    .bu_flush      (bu_flush),
    .bu_nxt_pc     (bu_nxt_pc),
    .st_flush      (st_flush),
    .st_nxt_pc     (st_nxt_pc),
    .if_instr      (if_instr),
    .if_pc         (if_pc),
    .if_bubble     (if_bubble),
    .if_exception  (if_exception),
    .if_bp_predict (if_bp_predict)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic expect_t fetch_model(input logic [xlen-1:0] pc);
    expect_t         r;
    logic [xlen-1:0] off;
    logic [xlen-1:0] raw;
    logic [xlen-1:0] imm;
    off   = pc - pc_init;
    r.exc = '0;
    r.exc[cause_misaligned_fetch]   = (pc[1:0] != 2'b00);
    r.exc[cause_fetch_access_fault] = (off >= imem_words * 4);  // below pc_init wraps high
    raw = (r.exc != '0) ? instr_nop : prog[off[7:2]];
    if (raw == instr_wfi) begin
      r.instr = instr_nop;
    end else if (raw[1:0] != 2'b11) begin
      r.instr = instr_illegal;  // 16 bit or other non-32 bit encoding
    end else begin
      r.instr = raw;
    end
    r.taken = 1'b0;
    imm     = '0;
    if (r.instr[6:2] == opc_jal) begin
      r.taken = 1'b1;
      imm = {{12{r.instr[31]}}, r.instr[19:12], r.instr[20], r.instr[30:21], 1'b0};
    end else if (r.instr[6:2] == opc_branch && r.instr[31]) begin
      r.taken = 1'b1;  // negative offset
      imm = {{20{r.instr[31]}}, r.instr[7], r.instr[30:25], r.instr[11:8], 1'b0};
    end
    r.next_pc = r.taken ? pc + imm : pc + 32'd4;
    return r;
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_instr(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: if_instr got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_pc(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: if_pc got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_exc(input logic [exc_size-1:0] got, input logic [exc_size-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: if_exception got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_pred(input logic [1:0] got, input logic [1:0] exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: if_bp_predict got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic check_bubble(input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: if_bubble got %b expected %b", $time, got, exp);
    end
  endtask

  // one recorded output against fixed values
  task automatic check_entry(input int idx, input logic [xlen-1:0] pc,
                             input logic [xlen-1:0] instr, input logic [exc_size-1:0] exc,
                             input logic [1:0] pred);
    if (idx < hist_pc.size()) begin
      check_pc(hist_pc[idx], pc);
      check_instr(hist_instr[idx], instr);
      check_exc(hist_exc[idx], exc);
      check_pred(hist_pred[idx], pred);
    end else begin
      errors++;
      $display("no output was recorded at position %0d", idx);
    end
  endtask

  ////////////////////////////////////////
  // monitor
  ////////////////////////////////////////

  initial begin
    logic            edge_rstn;
    logic            edge_stall;
    logic            edge_flush;
    logic            have_prev;
    logic [xlen-1:0] exp_pc;
    expect_t         r;
    logic [xlen-1:0]     prev_instr;
    logic [xlen-1:0]     prev_pc;
    logic                prev_bubble;
    logic [exc_size-1:0] prev_exc;
    logic [1:0]          prev_pred;
    have_prev = 1'b0;
    exp_pc    = pc_init;
    forever begin
      @(posedge clk);
      edge_rstn  = rstn;  // inputs seen by this edge
      edge_stall = id_stall;
      edge_flush = bu_flush | st_flush;
      if (st_flush) begin
        exp_pc = st_nxt_pc;  // state flush wins
      end else if (bu_flush) begin
        exp_pc = bu_nxt_pc;
      end
      @(negedge clk);  // outputs settled
      if (edge_rstn) begin
        if (edge_stall && !edge_flush && have_prev) begin
          check_instr(if_instr, prev_instr);  // frozen
          check_pc(if_pc, prev_pc);
          check_bubble(if_bubble, prev_bubble);
          check_exc(if_exception, prev_exc);
          check_pred(if_bp_predict, prev_pred);
        end else if (!edge_stall && !edge_flush && !if_bubble) begin
          r = fetch_model(exp_pc);
          check_pc(if_pc, exp_pc);
          check_instr(if_instr, r.instr);
          check_exc(if_exception, r.exc);
          check_pred(if_bp_predict, {r.taken, 1'b0});
          exp_pc = r.next_pc;
          hist_pc.push_back(if_pc);
          hist_instr.push_back(if_instr);
          hist_exc.push_back(if_exception);
          hist_pred.push_back(if_bp_predict);
        end
        have_prev = 1'b1;
      end
      prev_instr  = if_instr;
      prev_pc     = if_pc;
      prev_bubble = if_bubble;
      prev_exc    = if_exception;
      prev_pred   = if_bp_predict;
    end
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  task automatic wait_outputs(input int n, input string what);
    int cycles;
    cycles = 0;
    while (hist_pc.size() < n && cycles < 100) begin
      @(posedge clk);
      cycles++;
    end
    if (hist_pc.size() < n) begin
      errors++;
      $display("timed out after %0d cycles waiting for %s", cycles, what);
    end
  endtask

  // one cycle flush strobe that notes the history length at its edge
  task automatic apply_flush(input logic bu, input logic [xlen-1:0] bu_pc,
                             input logic st, input logic [xlen-1:0] st_pc);
    @(negedge clk);
    bu_flush  = bu;
    bu_nxt_pc = bu_pc;
    st_flush  = st;
    st_nxt_pc = st_pc;
    @(posedge clk);
    flush_mark = hist_pc.size();
    @(negedge clk);
    bu_flush = 1'b0;
    st_flush = 1'b0;
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %0d %s: passed", num, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", num, name, errors - err_before);
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    int              seed_init;
    int              t_err;
    int              mark;
    int              cycles;
    logic [xlen-1:0] walk_pc;
    expect_t         walk;
    seed_init = $urandom(32'hbdb2_ea06);
    rstn      = 1'b0;
    id_stall  = 1'b0;
    bu_flush  = 1'b0;
    bu_nxt_pc = pc_init;
    st_flush  = 1'b0;
    st_nxt_pc = pc_init;
    $readmemh("sim/prog.hex", prog);

    // straight line code from reset
    t_err = errors;
    repeat (3) @(posedge clk);  // three edges in reset
    @(negedge clk);
    check_bubble(if_bubble, 1'b1);  // reset values
    check_instr(if_instr, instr_nop);
    check_pc(if_pc, pc_init);
    check_exc(if_exception, '0);
    check_pred(if_bp_predict, 2'b00);
    rstn = 1'b1;
    wait_outputs(12, "the sequential stream");
    for (int i = 0; i < 12; i++) begin
      check_entry(i, pc_init + 4 * i, prog[6'(i)], '0, 2'b00);
    end
    report_test(1, "sequential stream", t_err);

    // forward branch falls through and jal skips two words before the backward loop
    t_err = errors;
    wait_outputs(25, "the predicted path");
    for (int i = 0; i < 13; i++) begin
      check_entry(12 + i, pc_init + 4 * path_idx[i],
                  (path_idx[i] == 13) ? instr_nop :
                  (path_idx[i] == 14) ? instr_illegal : prog[6'(path_idx[i])], '0,
                  (path_idx[i] == 15 || path_idx[i] == 20) ? 2'b10 : 2'b00);
    end
    foreach (hist_pc[i]) begin
      if (hist_pc[i] == pc_init + 32'd64 || hist_pc[i] == pc_init + 32'd68) begin
        errors++;
        $display("instruction from the skipped path at %h reached decode", hist_pc[i]);
      end
    end
    report_test(2, "static prediction", t_err);

    // rerun from pc_init under random stalls
    t_err = errors;
    apply_flush(1'b1, pc_init, 1'b0, pc_init);
    mark   = flush_mark;
    cycles = 0;
    while (hist_pc.size() < mark + 30 && cycles < 400) begin
      @(negedge clk);
      id_stall = ($urandom % 3 == 0);  // about one cycle in three
      @(posedge clk);
      cycles++;
    end
    @(negedge clk);
    id_stall = 1'b0;
    if (hist_pc.size() < mark + 30) begin
      errors++;
      $display("timed out after %0d cycles waiting for the stalled stream", cycles);
    end
    walk_pc = pc_init;  // same path as the unstalled run
    for (int i = 0; i < 25; i++) begin
      walk = fetch_model(walk_pc);
      check_entry(mark + i, walk_pc, walk.instr, walk.exc, {walk.taken, 1'b0});
      walk_pc = walk.next_pc;
    end
    report_test(3, "random decode stall", t_err);

    // external flushes
    t_err = errors;
    apply_flush(1'b1, pc_init + 32'd128, 1'b0, pc_init);
    mark = flush_mark;
    wait_outputs(mark + 3, "the branch unit flush target");
    check_entry(mark, pc_init + 32'd128, prog[32], '0, 2'b00);
    apply_flush(1'b1, pc_init + 32'd192, 1'b1, pc_init + 32'd160);  // both at once
    mark = flush_mark;
    wait_outputs(mark + 3, "the state flush target");
    check_entry(mark, pc_init + 32'd160, prog[40], '0, 2'b00);
    report_test(4, "external flushes", t_err);

    // bad fetch addresses
    t_err = errors;
    apply_flush(1'b1, pc_init + 32'd2, 1'b0, pc_init);
    mark = flush_mark;
    wait_outputs(mark + 2, "the misaligned fetch");
    check_entry(mark, pc_init + 32'd2, instr_nop, exc_mis, 2'b00);
    apply_flush(1'b1, pc_init + 32'd256, 1'b0, pc_init);  // first word past the memory
    mark = flush_mark;
    wait_outputs(mark + 2, "the out of range fetch");
    check_entry(mark, pc_init + 32'd256, instr_nop, exc_fault, 2'b00);
    report_test(5, "fetch exceptions", t_err);

    // wfi and a 16 bit encoding
    t_err = errors;
    apply_flush(1'b1, pc_init + 32'd52, 1'b0, pc_init);
    mark = flush_mark;
    wait_outputs(mark + 2, "the legalised words");
    check_entry(mark, pc_init + 32'd52, instr_nop, '0, 2'b00);
    check_entry(mark + 1, pc_init + 32'd56, instr_illegal, '0, 2'b00);
    report_test(6, "legalising", t_err);

    repeat (4) @(negedge clk);
    $display("done: %0d checks, %0d errors", n_checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
